//--- Bender.yml
package:
  name: agc_loop

sources:
  - include_dirs:
      - design
    files:
      - design/agc_bus_pkg.sv
      - design/agc_loop_pkg.sv
      - design/agc_reg_target.sv
      - design/agc_trig_master.sv
      - design/agc_loop_seq.sv
      - design/agc_loop_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/agc_trig_model.sv
      - test/agc_loop_chk.sv
      - test/agc_loop_tb.sv

//--- design/agc_bus_pkg.sv
package agc_bus_pkg;

    // Both Wishbone sides share the same widths
    typedef logic [21:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // Word offset of one beam inside a register block
    function automatic wb_addr_t beam_offset(input int unsigned idx);
        wb_addr_t off;
        off = wb_addr_t'(idx) << 2;
        return off;
    endfunction

endpackage

//--- design/agc_config.svh
`ifndef AGC_CONFIG_SVH
`define AGC_CONFIG_SVH

////////////////////
// Loop constants
////////////////////

`define AGC_NBEAMS        2
`define AGC_START_THRESH  4500  // Threshold after reset or the reset command
`define AGC_TARGET        100   // Counts per period
`define AGC_DELTA         2     // Fixed threshold step
`define AGC_MARGIN        10    // Dead band half width

////////////////////
// Register map
////////////////////

// Upstream, decoded on address bits 13:0
`define AGC_ADDR_CMD          14'h1000
`define AGC_ADDR_MANUAL_BASE  14'h0800
`define AGC_ADDR_MANUAL_MASK  14'h3800

// Trigger register bus
`define TRIG_ADDR_CTRL         22'h000   // Start, status and update-all
`define TRIG_ADDR_THRESH_BASE  22'h400   // Count read, threshold write
`define TRIG_ADDR_CE_BASE      22'h800   // Per beam clock enable

`endif

//--- design/agc_loop_pkg.sv
`include "agc_config.svh"

package agc_loop_pkg;

    typedef logic [17:0] thresh_t;  // Beam threshold
    typedef logic [31:0] count_t;   // Triggers seen in one period

    // Has to reach AGC_NBEAMS, the sequencer uses that value as loop end
    typedef logic [$clog2(`AGC_NBEAMS + 1)-1:0] beam_idx_t;

    // Loop state, requested by the host side and reached by the sequencer
    typedef enum logic [2:0] {
        RUNNING           = 3'd0,
        RESETTING         = 3'd1,  // Reset thresholds written, waiting for re-arm
        WRITE_RESET       = 3'd2,
        STOPPED           = 3'd3,
        WRITE_MANUAL      = 3'd4,
        WRITE_MANUAL_DONE = 3'd5   // Manual value applied, waiting for re-arm
    } loop_state_t;

endpackage

//--- design/agc_loop_seq.sv
`timescale 1ns/100ps
`include "agc_config.svh"

module agc_loop_seq
    import agc_bus_pkg::*, agc_loop_pkg::*;
(
    input  logic                      wb_clk_i,
    input  logic                      agc_reset,
    input  loop_state_t               loop_req_i,
    input  logic                      man_wr_i,
    input  beam_idx_t                 man_beam_i,
    input  thresh_t                   man_thresh_i,
    input  logic                      xfer_done_i,
    input  wb_data_t                  xfer_rdata_i,
    output loop_state_t               loop_state_o,
    output count_t  [`AGC_NBEAMS-1:0] counts_o,
    output thresh_t [`AGC_NBEAMS-1:0] thresholds_o,
    output logic                      xfer_start_o,
    output logic                      xfer_we_o,
    output wb_addr_t                  xfer_adr_o,
    output wb_data_t                  xfer_dat_o
);

    typedef enum logic [3:0] {
        SEQ_POLLING, SEQ_WAITING, SEQ_READING, SEQ_CALCULATING, SEQ_WRITING,
        SEQ_APPLYING, SEQ_UPDATING, SEQ_RESETTING, SEQ_MANUAL
    } seq_state_t;

    seq_state_t                 seq_state;
    beam_idx_t                  beam;
    logic                       busy;     // Start issued, done not yet seen
    thresh_t [`AGC_NBEAMS-1:0]  recalc;   // Next thresholds, applied on update-all

    task automatic send_xfer(input logic we, input wb_addr_t adr, input wb_data_t dat);
        xfer_start_o <= 1'b1;
        xfer_we_o    <= we;
        xfer_adr_o   <= adr;
        xfer_dat_o   <= dat;
        busy         <= 1'b1;
    endtask

    always_ff @(posedge wb_clk_i) begin
        if (agc_reset) begin
            seq_state    <= SEQ_WRITING;  // Straight to the starting thresholds
            beam         <= '0;
            busy         <= 1'b0;
            loop_state_o <= RUNNING;
            xfer_start_o <= 1'b0;
            counts_o     <= '0;
            recalc       <= {`AGC_NBEAMS{thresh_t'(`AGC_START_THRESH)}};
            thresholds_o <= {`AGC_NBEAMS{thresh_t'(`AGC_START_THRESH)}};
        end else begin
            xfer_start_o <= 1'b0;
            if (loop_req_i == RUNNING)
                loop_state_o <= RUNNING;
            else if (loop_req_i == STOPPED)
                loop_state_o <= STOPPED;
            if (man_wr_i && man_beam_i < beam_idx_t'(`AGC_NBEAMS))
                recalc[man_beam_i] <= man_thresh_i;

            case (seq_state)
                SEQ_POLLING: begin
                    if (loop_state_o == RESETTING) loop_state_o <= RUNNING;
                    if (loop_state_o == WRITE_MANUAL_DONE) loop_state_o <= STOPPED;
                    if (!busy) send_xfer(1'b1, `TRIG_ADDR_CTRL, 32'd1); // Start a period
                    else if (xfer_done_i) begin
                        busy      <= 1'b0;
                        seq_state <= SEQ_WAITING;
                    end
                end
                SEQ_WAITING: begin
                    if (!busy) begin
                        if (loop_req_i == RESETTING) seq_state <= SEQ_RESETTING;
                        else if (loop_req_i == WRITE_MANUAL_DONE) seq_state <= SEQ_MANUAL;
                        else send_xfer(1'b0, `TRIG_ADDR_CTRL, '0);  // Status poll
                    end else if (xfer_done_i) begin
                        busy <= 1'b0;
                        if (xfer_rdata_i[0]) begin
                            seq_state <= SEQ_READING;
                            beam      <= '0;
                        end
                    end
                end
                SEQ_READING: begin
                    if (beam < beam_idx_t'(`AGC_NBEAMS)) begin
                        if (!busy) send_xfer(1'b0, `TRIG_ADDR_THRESH_BASE + beam_offset(beam), '0);
                        else if (xfer_done_i) begin
                            busy           <= 1'b0;
                            counts_o[beam] <= xfer_rdata_i;
                            beam           <= beam + 1'b1;
                        end
                    end else begin
                        seq_state <= SEQ_CALCULATING;
                        beam      <= '0;
                    end
                end
                SEQ_CALCULATING: begin
                    if (loop_state_o == STOPPED) begin
                        seq_state <= SEQ_POLLING;  // Paused, thresholds stay
                    end else if (beam < beam_idx_t'(`AGC_NBEAMS)) begin
                        if (counts_o[beam] > `AGC_TARGET + `AGC_MARGIN)
                            recalc[beam] <= thresholds_o[beam] + thresh_t'(`AGC_DELTA);
                        else if (counts_o[beam] < `AGC_TARGET - `AGC_MARGIN)
                            recalc[beam] <= thresholds_o[beam] - thresh_t'(`AGC_DELTA);
                        beam <= beam + 1'b1;
                    end else begin
                        seq_state <= SEQ_WRITING;
                        beam      <= '0;
                    end
                end
                SEQ_WRITING, SEQ_APPLYING: begin
                    if (beam < beam_idx_t'(`AGC_NBEAMS)) begin
                        if (!busy && seq_state == SEQ_WRITING)
                            send_xfer(1'b1, `TRIG_ADDR_THRESH_BASE + beam_offset(beam),
                                      wb_data_t'(recalc[beam]));
                        else if (!busy)
                            send_xfer(1'b1, `TRIG_ADDR_CE_BASE + beam_offset(beam), 32'd1);
                        else if (xfer_done_i) begin
                            busy <= 1'b0;
                            beam <= beam + 1'b1;
                        end
                    end else begin
                        seq_state <= (seq_state == SEQ_WRITING) ? SEQ_APPLYING : SEQ_UPDATING;
                        beam      <= '0;
                    end
                end
                SEQ_UPDATING: begin
                    if (!busy) send_xfer(1'b1, `TRIG_ADDR_CTRL, 32'd2); // Update all at once
                    else if (xfer_done_i) begin
                        busy         <= 1'b0;
                        thresholds_o <= recalc;
                        seq_state    <= SEQ_POLLING;
                        if (loop_state_o == WRITE_RESET) loop_state_o <= RESETTING;
                        else if (loop_state_o == WRITE_MANUAL) loop_state_o <= WRITE_MANUAL_DONE;
                    end
                end
                SEQ_RESETTING: begin
                    recalc       <= {`AGC_NBEAMS{thresh_t'(`AGC_START_THRESH)}};
                    loop_state_o <= WRITE_RESET;
                    seq_state    <= SEQ_WRITING;
                    beam         <= '0;
                end
                SEQ_MANUAL: begin
                    loop_state_o <= WRITE_MANUAL;
                    seq_state    <= SEQ_WRITING;
                    beam         <= '0;
                end
                default: seq_state <= SEQ_POLLING;
            endcase
        end
    end

endmodule

//--- design/agc_loop_top.sv
`timescale 1ns/100ps
`include "agc_config.svh"

module agc_loop_top
    import agc_bus_pkg::*, agc_loop_pkg::*;
(
    input  logic       wb_clk_i,
    input  logic       agc_reset,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  wb_addr_t   wb_adr_i,
    input  wb_data_t   wb_dat_i,
    output logic       wb_ack_o,
    output wb_data_t   wb_dat_o,
    output logic       trig_cyc_o,
    output logic       trig_stb_o,
    output logic       trig_we_o,
    output wb_addr_t   trig_adr_o,
    output wb_data_t   trig_dat_o,
    output logic [3:0] trig_sel_o,
    input  logic       trig_ack_i,
    input  wb_data_t   trig_dat_i
);

    ////////////////////
    // Host to loop
    ////////////////////

    loop_state_t               loop_req;
    loop_state_t               loop_state;
    logic                      man_wr;
    beam_idx_t                 man_beam;
    thresh_t                   man_thresh;
    count_t  [`AGC_NBEAMS-1:0] counts;
    thresh_t [`AGC_NBEAMS-1:0] thresholds;

    ////////////////////
    // Loop to master
    ////////////////////

    logic     xfer_start;
    logic     xfer_we;
    wb_addr_t xfer_adr;
    wb_data_t xfer_dat;
    logic     xfer_done;
    wb_data_t xfer_rdata;

    agc_reg_target reg_target_i (
        .wb_clk_i     (wb_clk_i),
        .agc_reset    (agc_reset),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .loop_state_i (loop_state),
        .counts_i     (counts),
        .thresholds_i (thresholds),
        .wb_ack_o     (wb_ack_o),
        .wb_dat_o     (wb_dat_o),
        .loop_req_o   (loop_req),
        .man_wr_o     (man_wr),
        .man_beam_o   (man_beam),
        .man_thresh_o (man_thresh)
    );

    agc_loop_seq loop_seq_i (
        .wb_clk_i     (wb_clk_i),
        .agc_reset    (agc_reset),
        .loop_req_i   (loop_req),
        .man_wr_i     (man_wr),
        .man_beam_i   (man_beam),
        .man_thresh_i (man_thresh),
        .xfer_done_i  (xfer_done),
        .xfer_rdata_i (xfer_rdata),
        .loop_state_o (loop_state),
        .counts_o     (counts),
        .thresholds_o (thresholds),
        .xfer_start_o (xfer_start),
        .xfer_we_o    (xfer_we),
        .xfer_adr_o   (xfer_adr),
        .xfer_dat_o   (xfer_dat)
    );

    agc_trig_master trig_master_i (
        .wb_clk_i     (wb_clk_i),
        .agc_reset    (agc_reset),
        .xfer_start_i (xfer_start),
        .xfer_we_i    (xfer_we),
        .xfer_adr_i   (xfer_adr),
        .xfer_dat_i   (xfer_dat),
        .trig_ack_i   (trig_ack_i),
        .trig_dat_i   (trig_dat_i),
        .trig_cyc_o   (trig_cyc_o),
        .trig_stb_o   (trig_stb_o),
        .trig_we_o    (trig_we_o),
        .trig_adr_o   (trig_adr_o),
        .trig_dat_o   (trig_dat_o),
        .trig_sel_o   (trig_sel_o),
        .xfer_done_o  (xfer_done),
        .xfer_rdata_o (xfer_rdata)
    );

endmodule

//--- design/agc_reg_target.sv
`timescale 1ns/100ps
`include "agc_config.svh"

module agc_reg_target
    import agc_bus_pkg::*, agc_loop_pkg::*;
(
    input  logic                               wb_clk_i,
    input  logic                               agc_reset,
    input  logic                               wb_cyc_i,
    input  logic                               wb_stb_i,
    input  logic                               wb_we_i,
    input  wb_addr_t                           wb_adr_i,
    input  wb_data_t                           wb_dat_i,
    input  loop_state_t                        loop_state_i,
    input  count_t  [`AGC_NBEAMS-1:0]          counts_i,
    input  thresh_t [`AGC_NBEAMS-1:0]          thresholds_i,
    output logic                               wb_ack_o,
    output wb_data_t                           wb_dat_o,
    output loop_state_t                        loop_req_o,
    output logic                               man_wr_o,
    output beam_idx_t                          man_beam_o,
    output thresh_t                            man_thresh_o
);

    typedef enum logic [2:0] {ST_IDLE, ST_WRITE, ST_READ, ST_WAIT, ST_ACK} tgt_state_t;

    tgt_state_t state;
    beam_idx_t  adr_beam;
    logic       adr_beam_ok;
    logic       is_cmd;
    logic       is_manual;

    assign adr_beam    = beam_idx_t'(wb_adr_i[9:2]);
    assign adr_beam_ok = wb_adr_i[9:2] < 8'(`AGC_NBEAMS);
    assign is_cmd      = wb_adr_i[13:0] == `AGC_ADDR_CMD;
    assign is_manual   = (wb_adr_i[13:0] & `AGC_ADDR_MANUAL_MASK) == `AGC_ADDR_MANUAL_BASE;

    assign wb_ack_o = (state == ST_ACK);

    always_ff @(posedge wb_clk_i) begin
        if (agc_reset) begin
            state      <= ST_IDLE;
            loop_req_o <= RUNNING;
            man_wr_o   <= 1'b0;
        end else begin
            man_wr_o <= 1'b0;
            case (state)
                ST_IDLE: if (wb_cyc_i && wb_stb_i) begin
                    state <= wb_we_i ? ST_WRITE : ST_READ;
                end
                ST_WRITE: begin
                    state <= ST_WAIT;
                    if (is_cmd) begin
                        case (wb_dat_i)
                            32'd0:   loop_req_o <= RESETTING;
                            32'd1:   loop_req_o <= RUNNING;
                            32'd2:   loop_req_o <= STOPPED;
                            default: ;                   // Unknown command ignored
                        endcase
                    end else if (is_manual) begin
                        if (loop_state_i == STOPPED && loop_req_o != WRITE_MANUAL_DONE) begin
                            man_wr_o     <= 1'b1;
                            man_beam_o   <= adr_beam;
                            man_thresh_o <= wb_dat_i[17:0];
                            loop_req_o   <= WRITE_MANUAL_DONE;
                            wb_dat_o     <= 32'd1;
                        end else begin
                            wb_dat_o <= 32'd0;          // Refused, loop not paused
                        end
                    end
                end
                ST_READ: begin
                    state <= ST_WAIT;
                    if (wb_adr_i[10])
                        wb_dat_o <= adr_beam_ok ? counts_i[adr_beam] : '0;
                    else if (wb_adr_i[11])
                        wb_dat_o <= adr_beam_ok ? wb_data_t'(thresholds_i[adr_beam]) : '0;
                    else
                        wb_dat_o <= wb_data_t'(`AGC_DELTA);
                end
                ST_WAIT: begin
                    // Writes hold here until the sequencer catches up
                    if (!wb_we_i) begin
                        state <= ST_ACK;
                    end else if (loop_state_i == loop_req_o) begin
                        state <= ST_ACK;
                        if (loop_state_i == RESETTING)
                            loop_req_o <= RUNNING;      // Re-arm after reset
                        else if (loop_state_i == WRITE_MANUAL_DONE)
                            loop_req_o <= STOPPED;      // Back to pause
                    end
                end
                ST_ACK:  state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- design/agc_trig_master.sv
`timescale 1ns/100ps

module agc_trig_master
    import agc_bus_pkg::*;
(
    input  logic     wb_clk_i,
    input  logic     agc_reset,
    input  logic     xfer_start_i,
    input  logic     xfer_we_i,
    input  wb_addr_t xfer_adr_i,
    input  wb_data_t xfer_dat_i,
    input  logic     trig_ack_i,
    input  wb_data_t trig_dat_i,
    output logic     trig_cyc_o,
    output logic     trig_stb_o,
    output logic     trig_we_o,
    output wb_addr_t trig_adr_o,
    output wb_data_t trig_dat_o,
    output logic [3:0] trig_sel_o,
    output logic     xfer_done_o,
    output wb_data_t xfer_rdata_o
);

    assign trig_stb_o = trig_cyc_o;       // Single transfer per cycle
    assign trig_sel_o = {4{trig_cyc_o}};

    always_ff @(posedge wb_clk_i) begin
        if (agc_reset) begin
            trig_cyc_o  <= 1'b0;
            trig_we_o   <= 1'b0;
            trig_adr_o  <= '0;
            trig_dat_o  <= '0;
            xfer_done_o <= 1'b0;
        end else begin
            xfer_done_o <= 1'b0;
            if (!trig_cyc_o) begin
                if (xfer_start_i) begin
                    trig_cyc_o <= 1'b1;
                    trig_we_o  <= xfer_we_i;
                    trig_adr_o <= xfer_adr_i;
                    trig_dat_o <= xfer_dat_i;
                end
            end else if (trig_ack_i) begin // A late ack just stretches the cycle
                trig_cyc_o   <= 1'b0;
                trig_we_o    <= 1'b0;
                trig_adr_o   <= '0;
                trig_dat_o   <= '0;
                xfer_done_o  <= 1'b1;
                xfer_rdata_o <= trig_dat_i;
            end
        end
    end

endmodule

//--- test/agc_loop_chk.sv
`timescale 1ns/100ps

module agc_loop_chk (
    input logic       wb_clk_i,
    input logic       agc_reset,
    input logic       wb_ack_i,
    input logic       trig_cyc_i,
    input logic       trig_stb_i,
    input logic [3:0] trig_sel_i,
    input logic       trig_ack_i
);

    int unsigned assert_fails = 0;  // Read by the testbench at the end

    // Host ack is a single pulse
    ack_pulse: assert property (@(posedge wb_clk_i) disable iff (agc_reset)
        wb_ack_i |=> !wb_ack_i)
        else begin
            assert_fails++;
            $error("wb_ack_o stayed high for more than one cycle");
        end

    stb_is_cyc: assert property (@(posedge wb_clk_i) disable iff (agc_reset)
        trig_stb_i == trig_cyc_i)
        else begin
            assert_fails++;
            $error("trig_stb_o differs from trig_cyc_o");
        end

    // Strobe only drops after the trigger acked
    stb_held: assert property (@(posedge wb_clk_i) disable iff (agc_reset)
        $fell(trig_stb_i) |-> $past(trig_ack_i))
        else begin
            assert_fails++;
            $error("trig_stb_o dropped without an ack");
        end

    // Every transfer moves a full word
    sel_full: assert property (@(posedge wb_clk_i) disable iff (agc_reset)
        trig_cyc_i |-> trig_sel_i == 4'hf)
        else begin
            assert_fails++;
            $error("trig_sel_o not all ones during a transfer");
        end

    bus_idle_rst: assert property (@(posedge wb_clk_i)
        agc_reset && $past(agc_reset) |-> !trig_cyc_i && !trig_stb_i)
        else begin
            assert_fails++;
            $error("trigger bus active during reset");
        end

endmodule

bind agc_loop_top agc_loop_chk chk_i (
    .wb_clk_i   (wb_clk_i),
    .agc_reset  (agc_reset),
    .wb_ack_i   (wb_ack_o),
    .trig_cyc_i (trig_cyc_o),
    .trig_stb_i (trig_stb_o),
    .trig_sel_i (trig_sel_o),
    .trig_ack_i (trig_ack_i)
);

//--- test/agc_loop_tb.sv
`timescale 1ns/100ps
`include "agc_config.svh"

module agc_loop_tb
    import agc_bus_pkg::*, agc_loop_pkg::*;
();

    localparam int       CLK_HALF      = 20;
    localparam int       SEED          = 77541;
    localparam int       SETTLE_CYCLES = 3;  // Update-all ack reaches thresholds_o after 2
    // Under 20 loop iterations of about 55 cycles each leave a wide margin
    localparam int       TIMEOUT_CYCLES = 20000;
    localparam wb_addr_t DELTA_RD  = 22'h0;
    localparam wb_addr_t COUNT_RD  = 22'h400;
    localparam wb_addr_t THRESH_RD = 22'h800;
    localparam wb_addr_t CMD_WR    = wb_addr_t'(`AGC_ADDR_CMD);
    localparam wb_addr_t MANUAL_WR = wb_addr_t'(`AGC_ADDR_MANUAL_BASE);
    localparam thresh_t  MAN_VAL   = 18'h1234;

    // The stepping counts stay in place for one more iteration before the band test
    localparam wb_data_t UP2_THR = `AGC_START_THRESH + 2 * `AGC_DELTA;
    localparam wb_data_t DN2_THR = `AGC_START_THRESH - 2 * `AGC_DELTA;

    logic       wb_clk_i;
    logic       agc_reset;
    logic       wb_cyc_i;
    logic       wb_stb_i;
    logic       wb_we_i;
    wb_addr_t   wb_adr_i;
    wb_data_t   wb_dat_i;
    logic       wb_ack_o;
    wb_data_t   wb_dat_o;
    logic       trig_cyc_o;
    logic       trig_stb_o;
    logic       trig_we_o;
    wb_addr_t   trig_adr_o;
    wb_data_t   trig_dat_o;
    logic [3:0] trig_sel_o;
    logic       trig_ack_i;
    wb_data_t   trig_dat_i;

    int unsigned err_cnt = 0;
    int unsigned cycle_cnt;

    agc_loop_top dut_i (
        .wb_clk_i   (wb_clk_i),
        .agc_reset  (agc_reset),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_o   (wb_ack_o),
        .wb_dat_o   (wb_dat_o),
        .trig_cyc_o (trig_cyc_o),
        .trig_stb_o (trig_stb_o),
        .trig_we_o  (trig_we_o),
        .trig_adr_o (trig_adr_o),
        .trig_dat_o (trig_dat_o),
        .trig_sel_o (trig_sel_o),
        .trig_ack_i (trig_ack_i),
        .trig_dat_i (trig_dat_i)
    );

    agc_trig_model model_i (
        .wb_clk_i   (wb_clk_i),
        .agc_reset  (agc_reset),
        .trig_cyc_i (trig_cyc_o),
        .trig_stb_i (trig_stb_o),
        .trig_we_i  (trig_we_o),
        .trig_adr_i (trig_adr_o),
        .trig_dat_i (trig_dat_o),
        .trig_ack_o (trig_ack_i),
        .trig_dat_o (trig_dat_i)
    );

    ////////////////////
    // Clock, timeout
    ////////////////////

    initial begin
        wb_clk_i = 1'b0;
        forever #CLK_HALF wb_clk_i = ~wb_clk_i;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge wb_clk_i);
            cycle_cnt++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors: %0d", err_cnt + 1);
        $display("Test failures found");
        $finish;
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic wb_addr_t beam_reg(input wb_addr_t base, input int beam);
        return base | wb_addr_t'(beam * 4);
    endfunction

    task automatic check_eq(input string name, input wb_data_t exp, input wb_data_t got);
        if (exp !== got) begin
            err_cnt++;
            $display("[FAIL] %s exp 0x%08h got 0x%08h", name, exp, got);
        end
    endtask

    // One classic cycle, held until ack
    task automatic wb_xfer(input logic we, input wb_addr_t adr, input wb_data_t data,
                           output wb_data_t rdata);
        @(negedge wb_clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = data;
        @(negedge wb_clk_i);
        while (!wb_ack_o) @(negedge wb_clk_i);
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t data, output wb_data_t rdata);
        wb_xfer(1'b1, adr, data, rdata);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t rdata);
        wb_xfer(1'b0, adr, '0, rdata);
    endtask

    // Next update-all seen at the trigger, then let it reach thresholds_o
    task automatic wait_update();
        int unsigned seen;
        seen = model_i.update_cnt;
        while (model_i.update_cnt == seen) @(negedge wb_clk_i);
        repeat (SETTLE_CYCLES) @(negedge wb_clk_i);
    endtask

    task automatic wait_period();
        int unsigned seen;
        seen = model_i.period_cnt;
        while (model_i.period_cnt == seen) @(negedge wb_clk_i);
    endtask

    task automatic check_thresh(input int beam, input wb_data_t exp);
        wb_data_t rd;
        wb_read(beam_reg(THRESH_RD, beam), rd);
        check_eq($sformatf("threshold[%0d]", beam), exp, rd);
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic check_reset_state();
        wb_data_t rd;
        wb_read(DELTA_RD, rd);
        check_eq("delta", `AGC_DELTA, rd);
        for (int b = 0; b < `AGC_NBEAMS; b++) begin
            check_thresh(b, `AGC_START_THRESH);
        end
    endtask

    task automatic step_rates();
        wb_data_t rd;
        wait_update();  // Counts change before the next period is read
        model_i.set_count(0, `AGC_TARGET + `AGC_MARGIN + 30);
        model_i.set_count(1, `AGC_TARGET - `AGC_MARGIN - 30);
        wait_update();
        check_thresh(0, `AGC_START_THRESH + `AGC_DELTA);
        check_thresh(1, `AGC_START_THRESH - `AGC_DELTA);
        wb_read(beam_reg(COUNT_RD, 0), rd);
        check_eq("count[0]", `AGC_TARGET + `AGC_MARGIN + 30, rd);
        wb_read(beam_reg(COUNT_RD, 1), rd);
        check_eq("count[1]", `AGC_TARGET - `AGC_MARGIN - 30, rd);
    endtask

    task automatic hold_dead_band();
        wb_data_t    rd;
        int unsigned band;
        for (int i = 0; i < 3; i++) begin
            band = `AGC_TARGET - `AGC_MARGIN + ($urandom % (2 * `AGC_MARGIN + 1));
            wait_update();
            model_i.set_count(0, `AGC_TARGET);
            model_i.set_count(1, band);
            wait_update();
            check_thresh(0, UP2_THR);
            check_thresh(1, DN2_THR);
            wb_read(beam_reg(COUNT_RD, 1), rd);
            check_eq("count[1]", band, rd);
        end
    endtask

    task automatic pause_and_manual();
        wb_data_t rd;
        wb_write(beam_reg(MANUAL_WR, 0), MAN_VAL, rd);
        check_eq("manual ack running", 32'd0, rd);
        check_thresh(0, UP2_THR);

        wb_write(CMD_WR, 32'd2, rd);             // Pause
        wb_write(beam_reg(MANUAL_WR, 0), MAN_VAL, rd);
        check_eq("manual ack paused", 32'd1, rd);
        check_thresh(0, MAN_VAL);
        check_thresh(1, DN2_THR);
        check_eq("trigger threshold[0]", MAN_VAL, model_i.thresh_wr[0]);

        // Far out of band, yet paused periods must not step
        model_i.set_count(0, `AGC_TARGET + 100);
        model_i.set_count(1, 0);
        wait_period();
        wait_period();
        check_thresh(0, MAN_VAL);
        check_thresh(1, DN2_THR);
    endtask

    task automatic reset_command();
        wb_data_t rd;
        model_i.set_count(0, `AGC_TARGET + 100);
        model_i.set_count(1, `AGC_TARGET + 100);
        wb_write(CMD_WR, 32'd0, rd);
        for (int b = 0; b < `AGC_NBEAMS; b++) begin
            check_thresh(b, `AGC_START_THRESH);
            check_eq($sformatf("trigger threshold[%0d]", b), `AGC_START_THRESH,
                     model_i.thresh_wr[b]);
        end
        wb_write(CMD_WR, 32'd1, rd);             // Run
        wait_update();
        for (int b = 0; b < `AGC_NBEAMS; b++) begin
            check_thresh(b, `AGC_START_THRESH + `AGC_DELTA);
        end
        wait_update();
        for (int b = 0; b < `AGC_NBEAMS; b++) begin
            check_thresh(b, `AGC_START_THRESH + 2 * `AGC_DELTA);
        end
    endtask

    initial begin
        agc_reset = 1'b1;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        void'($urandom(SEED));
        repeat (2) @(negedge wb_clk_i);
        agc_reset = 1'b0;

        check_reset_state();
        step_rates();
        hold_dead_band();
        pause_and_manual();
        reset_command();

        err_cnt += dut_i.chk_i.assert_fails;
        $display("Errors: %0d", err_cnt);
        if (err_cnt == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- test/agc_trig_model.sv
`timescale 1ns/100ps
`include "agc_config.svh"

module agc_trig_model
    import agc_bus_pkg::*, agc_loop_pkg::*;
(
    input  logic     wb_clk_i,
    input  logic     agc_reset,
    input  logic     trig_cyc_i,
    input  logic     trig_stb_i,
    input  logic     trig_we_i,
    input  wb_addr_t trig_adr_i,
    input  wb_data_t trig_dat_i,
    output logic     trig_ack_o,
    output wb_data_t trig_dat_o
);

    count_t      beam_count [`AGC_NBEAMS];  // Returned on count reads
    thresh_t     thresh_wr  [`AGC_NBEAMS];  // Last threshold written per beam
    logic        period_done;
    int unsigned period_cnt;                // Start commands seen
    int unsigned update_cnt;                // Update-all commands seen
    logic        in_block;
    wb_addr_t    beam_sel;

    assign in_block = trig_adr_i >= `TRIG_ADDR_THRESH_BASE
                      && trig_adr_i < `TRIG_ADDR_THRESH_BASE + 4 * `AGC_NBEAMS;
    assign beam_sel = (trig_adr_i - `TRIG_ADDR_THRESH_BASE) >> 2;

    initial begin
        trig_ack_o = 1'b0;
        trig_dat_o = '0;
        for (int b = 0; b < `AGC_NBEAMS; b++) begin
            beam_count[b] = `AGC_TARGET;  // In band, so the loop holds still
        end
    end

    task automatic set_count(input int beam, input count_t value);
        beam_count[beam] = value;
    endtask

    always @(posedge wb_clk_i) begin
        if (agc_reset) begin
            trig_ack_o  <= 1'b0;
            trig_dat_o  <= '0;
            period_done <= 1'b0;
            period_cnt  <= 0;
            update_cnt  <= 0;
            for (int b = 0; b < `AGC_NBEAMS; b++) begin
                thresh_wr[b] <= '0;
            end
        end else begin
            trig_ack_o <= 1'b0;
            if (trig_cyc_i && trig_stb_i && !trig_ack_o) begin
                trig_ack_o <= 1'b1;
                trig_dat_o <= '0;
                if (trig_we_i) begin
                    if (trig_adr_i == `TRIG_ADDR_CTRL && trig_dat_i == 32'd1) begin
                        period_done <= 1'b1;
                        period_cnt  <= period_cnt + 1;
                    end else if (trig_adr_i == `TRIG_ADDR_CTRL && trig_dat_i == 32'd2) begin
                        update_cnt <= update_cnt + 1;
                    end else if (in_block) begin
                        thresh_wr[beam_sel] <= trig_dat_i[17:0];
                    end
                    // Clock enable writes are acked and dropped
                end else if (trig_adr_i == `TRIG_ADDR_CTRL) begin
                    trig_dat_o  <= {31'd0, period_done};  // Done on the first poll after start
                    period_done <= 1'b0;
                end else if (in_block) begin
                    trig_dat_o <= beam_count[beam_sel];
                end
            end
        end
    end

endmodule

//--- vlog.f
+incdir+design
design/agc_bus_pkg.sv
design/agc_loop_pkg.sv
design/agc_reg_target.sv
design/agc_trig_master.sv
design/agc_loop_seq.sv
design/agc_loop_top.sv
test/agc_trig_model.sv
test/agc_loop_chk.sv
test/agc_loop_tb.sv
